// File: include/backend_defs.svh
`ifndef BACKEND_DEFS_SVH
`define BACKEND_DEFS_SVH

// Datapath and PC width
`define DATA_W   32

// Architectural register file
`define NREG     32
`define RADDR_W  5

// Decoded-instruction queue entries
`define IQ_DEPTH 8

`endif

// File: hdl/backend_pkg.sv
`include "backend_defs.svh"

package backend_pkg;

    typedef enum logic {
        CLS_ALU    = 1'b0,
        CLS_BRANCH = 1'b1
    } inst_class_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
        ALU_XOR, ALU_SLL, ALU_SRL, ALU_SLT
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_BEQ, BR_BNE, BR_BLT, BR_BGE
    } br_type_e;

    typedef struct packed {
        logic                valid;
        logic [`DATA_W-1:0]  pc;
        logic [`DATA_W-1:0]  pc_pre;    // Predicted next PC
        inst_class_e         cls;
        alu_op_e             alu_op;
        br_type_e            br_type;
        logic [`RADDR_W-1:0] rs1;
        logic [`RADDR_W-1:0] rs2;
        logic [`RADDR_W-1:0] rd;
        logic                rf_we;
        logic [`DATA_W-1:0]  imm;
        logic                src2_imm;  // Operand 2 from imm
    } issue_set_t;

    typedef struct packed {
        issue_set_t         set;        // set.valid is the lane enable
        logic [`DATA_W-1:0] rdata1;
        logic [`DATA_W-1:0] rdata2;
    } ex_slot_t;

    typedef struct packed {
        logic                valid;
        logic [`DATA_W-1:0]  pc;
        logic                rf_we;
        logic [`RADDR_W-1:0] rd;
        logic [`DATA_W-1:0]  data;
    } commit_t;

    typedef struct packed {
        logic               valid;
        logic [`DATA_W-1:0] target;
    } redirect_t;

endpackage

// File: hdl/issue_buffer.sv
`include "backend_defs.svh"

module issue_buffer
    import backend_pkg::*;
#(
    parameter int DEPTH = `IQ_DEPTH
) (
    input  logic       clk,
    input  logic       rstn,
    input  logic       i_push,
    input  issue_set_t i_in,
    input  logic       i_stall,
    input  redirect_t  i_redirect,
    input  ex_slot_t   i_ex_a,
    input  ex_slot_t   i_ex_b,
    output logic       o_full,
    output issue_set_t o_set1,
    output issue_set_t o_set2
);

    localparam int PW = $clog2(DEPTH);

    issue_set_t    mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW-1:0] rd_ptr_1;
    logic [PW:0]   count;
    issue_set_t    head;
    issue_set_t    second;
    logic          push_ok;
    logic          can_pop;
    logic          hold_head;
    logic          pair_ok;
    logic          pop1;
    logic          pop2;
    logic [1:0]    pop_n;

    function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
        ptr_inc = (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    function automatic logic ex_hit(input ex_slot_t ex, input logic [`RADDR_W-1:0] r);
        ex_hit = ex.set.valid && ex.set.rf_we && (ex.set.rd != '0) && (ex.set.rd == r);
    endfunction

    function automatic logic ex_hazard(input issue_set_t s, input ex_slot_t a,
                                       input ex_slot_t b);
        ex_hazard = ex_hit(a, s.rs1) || ex_hit(a, s.rs2) ||
                    ex_hit(b, s.rs1) || ex_hit(b, s.rs2);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Pop decision

    assign head     = mem[rd_ptr];
    assign rd_ptr_1 = ptr_inc(rd_ptr);
    assign second   = mem[rd_ptr_1];

    assign can_pop   = !i_stall && !i_redirect.valid;
    assign hold_head = ex_hazard(head, i_ex_a, i_ex_b);  // Producer still in execute
    assign pop1      = can_pop && (count != '0) && !hold_head;

    assign pair_ok = (head.cls == CLS_ALU) &&
                     !(head.rf_we && (head.rd != '0) &&
                       ((second.rs1 == head.rd) || (second.rs2 == head.rd))) &&
                     !(head.rf_we && second.rf_we && (head.rd == second.rd)) &&
                     !ex_hazard(second, i_ex_a, i_ex_b);
    assign pop2    = pop1 && (count >= (PW+1)'(2)) && pair_ok;
    assign pop_n   = {1'b0, pop1} + {1'b0, pop2};

    always_comb begin
        o_set1       = head;
        o_set1.valid = pop1;
        o_set2       = second;
        o_set2.valid = pop2;
    end

    //////////////////////////////////////////////////////////////////////
    // Queue state

    assign o_full  = (count == (PW+1)'(DEPTH));
    assign push_ok = i_push && !o_full && !i_redirect.valid;  // Wrong-path push dropped

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (i_redirect.valid) begin  // Flush all entries
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop2) begin
                rd_ptr <= ptr_inc(rd_ptr_1);
            end else if (pop1) begin
                rd_ptr <= rd_ptr_1;
            end
            count <= count + (PW+1)'(push_ok) - (PW+1)'(pop_n);
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= i_in;
        end
    end

endmodule

// File: hdl/reg_file.sv
`include "backend_defs.svh"

module reg_file
    import backend_pkg::*;
(
    input  logic                          clk,
    input  logic                          rstn,
    input  logic [3:0][`RADDR_W-1:0]      i_rs,
    input  commit_t                       i_wr_a,
    input  commit_t                       i_wr_b,
    output logic [3:0][`DATA_W-1:0]       o_rdata
);

    logic [`DATA_W-1:0] regs [`NREG];
    logic               we_a;
    logic               we_b;

    assign we_a = i_wr_a.valid && i_wr_a.rf_we && (i_wr_a.rd != '0);
    assign we_b = i_wr_b.valid && i_wr_b.rf_we && (i_wr_b.rd != '0);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < `NREG; i++) begin
                regs[i] <= '0;  // Architectural state starts at zero
            end
        end else begin
            if (we_a) begin
                regs[i_wr_a.rd] <= i_wr_a.data;
            end
            if (we_b) begin
                regs[i_wr_b.rd] <= i_wr_b.data;
            end
        end
    end

    // Write-through so a consumer can issue alongside its producer's commit
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            if (i_rs[p] == '0) begin
                o_rdata[p] = '0;
            end else if (we_b && (i_wr_b.rd == i_rs[p])) begin
                o_rdata[p] = i_wr_b.data;
            end else if (we_a && (i_wr_a.rd == i_rs[p])) begin
                o_rdata[p] = i_wr_a.data;
            end else begin
                o_rdata[p] = regs[i_rs[p]];
            end
        end
    end

endmodule

// File: hdl/issue_exe.sv
`include "backend_defs.svh"

module issue_exe
    import backend_pkg::*;
(
    input  logic                    clk,
    input  logic                    rstn,
    input  issue_set_t              i_set1,
    input  issue_set_t              i_set2,
    input  logic [3:0][`DATA_W-1:0] i_rdata,  // set1 rs1/rs2, set2 rs1/rs2
    input  logic                    i_stall,
    input  redirect_t               i_redirect,
    output ex_slot_t                o_ex_a,
    output ex_slot_t                o_ex_b
);

    ex_slot_t slot_1;
    ex_slot_t slot_2;
    logic     swap;
    logic     load;

    // Assemble each instruction with its operand values
    always_comb begin
        slot_1           = '0;
        slot_1.set       = i_set1;
        slot_1.set.valid = i_set1.valid && !i_redirect.valid;  // Killed by flush
        slot_1.rdata1    = i_rdata[0];
        slot_1.rdata2    = i_rdata[1];

        slot_2           = '0;
        slot_2.set       = i_set2;
        slot_2.set.valid = i_set2.valid && !i_redirect.valid;
        slot_2.rdata1    = i_rdata[2];
        slot_2.rdata2    = i_rdata[3];
    end

    // Lane A is ALU only, so a non-ALU older instruction moves to lane B
    assign swap = i_set1.valid && (i_set1.cls != CLS_ALU);

    // Flush overrides stall
    assign load = i_redirect.valid || !i_stall;

    //////////////////////////////////////////////////////////////////////
    // Issue/execute register

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_ex_a.set.valid <= 1'b0;
            o_ex_b.set.valid <= 1'b0;
        end else if (load) begin
            if (swap) begin
                o_ex_a <= slot_2;
                o_ex_b <= slot_1;
            end else begin
                o_ex_a <= slot_1;
                o_ex_b <= slot_2;
            end
        end
    end

endmodule

// File: hdl/exe_lane.sv
`include "backend_defs.svh"

module exe_lane
    import backend_pkg::*;
#(
    parameter bit HAS_BRANCH = 1'b0
) (
    input  logic      clk,
    input  logic      rstn,
    input  ex_slot_t  i_ex,
    input  logic      i_stall,
    input  logic      i_redirect_kill,
    output commit_t   o_commit,
    output redirect_t o_redirect
);

    logic [`DATA_W-1:0] op1;
    logic [`DATA_W-1:0] op2;
    logic [`DATA_W-1:0] alu_res;
    commit_t            commit_q;

    //////////////////////////////////////////////////////////////////////
    // ALU

    assign op1 = i_ex.rdata1;
    assign op2 = i_ex.set.src2_imm ? i_ex.set.imm : i_ex.rdata2;

    always_comb begin
        case (i_ex.set.alu_op)
            ALU_ADD: alu_res = op1 + op2;
            ALU_SUB: alu_res = op1 - op2;
            ALU_AND: alu_res = op1 & op2;
            ALU_OR:  alu_res = op1 | op2;
            ALU_XOR: alu_res = op1 ^ op2;
            ALU_SLL: alu_res = op1 << op2[4:0];
            ALU_SRL: alu_res = op1 >> op2[4:0];
            ALU_SLT: alu_res = `DATA_W'($signed(op1) < $signed(op2));
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Commit register, held through a stall and hidden while it lasts

    always_ff @(posedge clk) begin
        if (!rstn) begin
            commit_q.valid <= 1'b0;
        end else if (!i_stall) begin
            commit_q.valid <= i_ex.set.valid && !i_redirect_kill;  // Wrong path dropped
            commit_q.pc    <= i_ex.set.pc;
            commit_q.rf_we <= i_ex.set.rf_we;
            commit_q.rd    <= i_ex.set.rd;
            commit_q.data  <= alu_res;
        end
    end

    always_comb begin
        o_commit       = commit_q;
        o_commit.valid = commit_q.valid && !i_stall;
    end

    generate
        if (HAS_BRANCH) begin : g_branch
            logic               taken;
            logic               mispredict;
            logic [`DATA_W-1:0] next_pc;
            redirect_t          redir_q;

            always_comb begin
                case (i_ex.set.br_type)
                    BR_BEQ: taken = (i_ex.rdata1 == i_ex.rdata2);
                    BR_BNE: taken = (i_ex.rdata1 != i_ex.rdata2);
                    BR_BLT: taken = ($signed(i_ex.rdata1) <  $signed(i_ex.rdata2));
                    BR_BGE: taken = ($signed(i_ex.rdata1) >= $signed(i_ex.rdata2));
                endcase
            end

            assign next_pc    = taken ? (i_ex.set.pc + i_ex.set.imm) : (i_ex.set.pc + 'd4);
            assign mispredict = i_ex.set.valid && (i_ex.set.cls == CLS_BRANCH) &&
                                (next_pc != i_ex.set.pc_pre);

            always_ff @(posedge clk) begin
                if (!rstn) begin
                    redir_q.valid <= 1'b0;
                end else if (!i_stall) begin
                    redir_q.valid  <= mispredict && !i_redirect_kill;
                    redir_q.target <= next_pc;
                end
            end

            always_comb begin
                o_redirect       = redir_q;
                o_redirect.valid = redir_q.valid && !i_stall;
            end
        end else begin : g_no_branch
            assign o_redirect = '0;  // ALU-only lane
        end
    endgenerate

endmodule

// File: hdl/issue_exec_backend.sv
`include "backend_defs.svh"

module issue_exec_backend
    import backend_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       i_push,
    input  issue_set_t i_in,
    input  logic       i_stall,
    output logic       o_full,
    output commit_t    o_commit_a,
    output commit_t    o_commit_b,
    output redirect_t  o_redirect
);

    issue_set_t              set1;
    issue_set_t              set2;
    logic [3:0][`DATA_W-1:0] rdata;
    ex_slot_t                ex_a;
    ex_slot_t                ex_b;

    issue_buffer #(
        .DEPTH      (`IQ_DEPTH)
    ) u_issue_buffer (
        .clk        (clk),
        .rstn       (rstn),
        .i_push     (i_push),
        .i_in       (i_in),
        .i_stall    (i_stall),
        .i_redirect (o_redirect),
        .i_ex_a     (ex_a),
        .i_ex_b     (ex_b),
        .o_full     (o_full),
        .o_set1     (set1),
        .o_set2     (set2)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .rstn       (rstn),
        .i_rs       ({set2.rs2, set2.rs1, set1.rs2, set1.rs1}),
        .i_wr_a     (o_commit_a),
        .i_wr_b     (o_commit_b),
        .o_rdata    (rdata)
    );

    issue_exe u_issue_exe (
        .clk        (clk),
        .rstn       (rstn),
        .i_set1     (set1),
        .i_set2     (set2),
        .i_rdata    (rdata),
        .i_stall    (i_stall),
        .i_redirect (o_redirect),
        .o_ex_a     (ex_a),
        .o_ex_b     (ex_b)
    );

    exe_lane #(
        .HAS_BRANCH      (1'b0)
    ) u_lane_a (
        .clk             (clk),
        .rstn            (rstn),
        .i_ex            (ex_a),
        .i_stall         (i_stall),
        .i_redirect_kill (o_redirect.valid),
        .o_commit        (o_commit_a),
        .o_redirect      ()
    );

    exe_lane #(
        .HAS_BRANCH      (1'b1)
    ) u_lane_b (
        .clk             (clk),
        .rstn            (rstn),
        .i_ex            (ex_b),
        .i_stall         (i_stall),
        .i_redirect_kill (o_redirect.valid),  // Own redirect kills the wrong path
        .o_commit        (o_commit_b),
        .o_redirect      (o_redirect)
    );

endmodule

// File: test/backend_checker.sv
`include "backend_defs.svh"

module backend_checker
    import backend_pkg::*;
(
    input logic      clk,
    input logic      rstn,
    input logic      i_stall,
    input redirect_t i_redirect,
    input ex_slot_t  i_ex_a,
    input ex_slot_t  i_ex_b
);

    a_lane_a_alu_only : assert property (@(posedge clk) disable iff (!rstn)
        !(i_ex_a.set.valid && (i_ex_a.set.cls == CLS_BRANCH)))
        else $error("Lane A holds a valid branch");

    a_stall_hold : assert property (@(posedge clk) disable iff (!rstn)
        (rstn && i_stall && !i_redirect.valid) |=>
            ((i_ex_a === $past(i_ex_a)) && (i_ex_b === $past(i_ex_b))))
        else $error("Execute stage changed during a stall");

    a_no_double_write : assert property (@(posedge clk) disable iff (!rstn)
        !(i_ex_a.set.valid && i_ex_b.set.valid && i_ex_a.set.rf_we && i_ex_b.set.rf_we &&
          (i_ex_a.set.rd != '0) && (i_ex_a.set.rd == i_ex_b.set.rd)))
        else $error("Both lanes write the same register");

    a_flush_clears : assert property (@(posedge clk) disable iff (!rstn)
        (rstn && i_redirect.valid) |=> (!i_ex_a.set.valid && !i_ex_b.set.valid))
        else $error("Execute stage still valid after a redirect");

endmodule

// File: test/tb_backend.sv
`include "backend_defs.svh"

module tb_backend
    import backend_pkg::*;
();

    localparam int PROG_N   = 64;
    localparam int N_COMMIT = 400;
    localparam int IDLE_MAX = 200;

    logic               clk;
    logic               rstn;
    logic               i_push;
    issue_set_t         i_in;
    logic               i_stall;
    logic               o_full;
    commit_t            o_commit_a;
    commit_t            o_commit_b;
    redirect_t          o_redirect;

    issue_set_t         prog [PROG_N];
    logic               pred_taken [PROG_N];
    logic [`DATA_W-1:0] model_regs [`NREG];
    logic [`DATA_W-1:0] model_pc;
    redirect_t          model_redir;  // Redirect expected after the last retired instruction
    logic [`DATA_W-1:0] drv_pc;
    integer             seed;
    int                 n_commit;
    int                 idle;
    int                 cycle;
    int                 first_push;

    issue_exec_backend u_issue_exec_backend (
        .clk        (clk),
        .rstn       (rstn),
        .i_push     (i_push),
        .i_in       (i_in),
        .i_stall    (i_stall),
        .o_full     (o_full),
        .o_commit_a (o_commit_a),
        .o_commit_b (o_commit_b),
        .o_redirect (o_redirect)
    );

    bind issue_exe backend_checker u_backend_checker (
        .clk        (clk),
        .rstn       (rstn),
        .i_stall    (i_stall),
        .i_redirect (i_redirect),
        .i_ex_a     (o_ex_a),
        .i_ex_b     (o_ex_b)
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Reference model

    function automatic logic [`DATA_W-1:0] alu_ref(input alu_op_e op,
                                                   input logic [`DATA_W-1:0] a,
                                                   input logic [`DATA_W-1:0] b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            default: return {{(`DATA_W-1){1'b0}}, ($signed(a) < $signed(b))};  // SLT
        endcase
    endfunction

    function automatic logic taken_ref(input br_type_e t, input logic [`DATA_W-1:0] a,
                                       input logic [`DATA_W-1:0] b);
        case (t)
            BR_BEQ:  return a == b;
            BR_BNE:  return a != b;
            BR_BLT:  return $signed(a) < $signed(b);
            default: return $signed(a) >= $signed(b);
        endcase
    endfunction

    // Program repeats every 64 words, so PCs only grow
    function automatic issue_set_t fetch(input logic [`DATA_W-1:0] pc);
        issue_set_t s;
        s        = prog[pc[7:2]];
        s.valid  = 1'b1;
        s.pc     = pc;
        s.pc_pre = pred_taken[pc[7:2]] ? pc + s.imm : pc + 32'd4;
        return s;
    endfunction

    task automatic build_program();
        for (int i = 0; i < PROG_N; i++) begin
            prog[i]     = '0;
            prog[i].rs1 = 5'($random(seed) & 7);  // Few registers, many hazards
            prog[i].rs2 = 5'($random(seed) & 7);
            if (({$random(seed)} % 6) == 0) begin
                prog[i].cls     = CLS_BRANCH;
                prog[i].br_type = br_type_e'(2'($random(seed)));
                prog[i].imm     = 32'((({$random(seed)} % 8) + 2) * 4);  // Forward only
                pred_taken[i]   = 1'($random(seed));
            end else begin
                prog[i].cls      = CLS_ALU;
                prog[i].alu_op   = alu_op_e'(3'($random(seed)));
                prog[i].rd       = 5'($random(seed) & 7);
                prog[i].rf_we    = ({$random(seed)} % 8) != 0;
                prog[i].imm      = $random(seed);
                prog[i].src2_imm = 1'($random(seed));
                pred_taken[i]    = 1'b0;
            end
        end
    endtask

    task automatic model_step(output commit_t c);
        issue_set_t         s;
        logic [`DATA_W-1:0] a;
        logic [`DATA_W-1:0] b;
        logic [`DATA_W-1:0] nxt;
        s       = fetch(model_pc);
        a       = model_regs[s.rs1];
        b       = model_regs[s.rs2];
        c.valid = 1'b1;
        c.pc    = s.pc;
        c.rf_we = s.rf_we;
        c.rd    = s.rd;
        c.data  = alu_ref(s.alu_op, a, s.src2_imm ? s.imm : b);
        nxt     = s.pc + 32'd4;
        if ((s.cls == CLS_BRANCH) && taken_ref(s.br_type, a, b)) begin
            nxt = s.pc + s.imm;
        end
        model_redir.valid  = (s.cls == CLS_BRANCH) && (nxt != s.pc_pre);
        model_redir.target = nxt;
        if (s.rf_we && (s.rd != '0)) begin
            model_regs[s.rd] = c.data;
        end
        model_pc = nxt;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checks

    task automatic stop_with_failure();
        $display("Test FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_commit(input string name, input commit_t got, input commit_t exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got=%h exp=%h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_redirect(input string name, input redirect_t got,
                                  input redirect_t exp);
        if ((got.valid !== exp.valid) || (exp.valid && (got.target !== exp.target))) begin
            $display("[FAIL] t=%0t %s got=%h exp=%h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic retire(input string name, input commit_t got);
        commit_t exp;
        model_step(exp);
        check_commit(name, got, exp);
        n_commit++;
        idle = 0;
    endtask

    task automatic drive_inputs();
        i_stall = ({$random(seed)} % 8) == 0;
        i_push  = !o_full;
        i_in    = o_full ? '0 : fetch(drv_pc);
        if (i_push && (first_push < 0)) begin
            first_push = cycle;
        end
    endtask

    task automatic check_outputs();
        logic      b_first;
        redirect_t exp_r;
        if (i_stall && (o_commit_a.valid || o_commit_b.valid)) begin
            $display("Commit marked valid while the stall input is high at t=%0t", $time);
            stop_with_failure();
        end
        if (((first_push < 0) || (cycle < first_push + 3)) &&
            (o_commit_a.valid || o_commit_b.valid || o_redirect.valid)) begin
            $display("Output valid before the first instruction could commit at t=%0t", $time);
            stop_with_failure();
        end
        idle++;
        b_first = o_commit_a.valid && o_commit_b.valid && (o_commit_b.pc < o_commit_a.pc);
        if (b_first) begin
            retire("o_commit_b", o_commit_b);
        end
        if (o_commit_a.valid) begin
            retire("o_commit_a", o_commit_a);
        end
        if (o_commit_b.valid && !b_first) begin
            retire("o_commit_b", o_commit_b);
        end
        exp_r = (o_commit_a.valid || o_commit_b.valid) ? model_redir : '0;
        check_redirect("o_redirect", o_redirect, exp_r);
        if (o_redirect.valid) begin
            drv_pc = o_redirect.target;  // Front end restarts, pushed wrong path is gone
        end else if (i_push) begin
            drv_pc = i_in.pc_pre;
        end
    endtask

    initial begin
        clk        = 1'b0;
        rstn       = 1'b0;
        i_push     = 1'b0;
        i_in       = '0;
        i_stall    = 1'b0;
        seed       = 32'hae24;
        model_pc   = '0;
        drv_pc     = '0;
        n_commit   = 0;
        idle       = 0;
        cycle      = 0;
        first_push = -1;
        for (int r = 0; r < `NREG; r++) begin
            model_regs[r] = '0;
        end
        build_program();
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;
        while (n_commit < N_COMMIT) begin
            drive_inputs();
            @(negedge clk);
            check_outputs();
            if (idle > IDLE_MAX) begin
                $display("Pipeline stopped committing for %0d cycles at t=%0t", IDLE_MAX, $time);
                stop_with_failure();
            end
            @(posedge clk);
            #1;
            cycle++;
        end
        $display("Test OK");
        $finish;
    end

endmodule

// File: project.f
+incdir+include
hdl/backend_pkg.sv
hdl/issue_buffer.sv
hdl/reg_file.sv
hdl/issue_exe.sv
hdl/exe_lane.sv
hdl/issue_exec_backend.sv
test/backend_checker.sv
test/tb_backend.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_backend \
    -f project.f -o tb_backend > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/tb_backend > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "Test FAILED" "$SIM_LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
echo "Simulation passed"
